// ==== list.f ====
logic/rf_pkg.sv
logic/rf_addr_map.sv
logic/rf_bank.sv
logic/rf_access_ctrl.sv
logic/regfile_hot_cold.sv
verif/regfile_sva.sv
verif/regfile_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the register file testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
        -f list.f \
        --top-module regfile_tb \
        -o regfile_sim

out=$(./obj_dir/regfile_sim)
echo "$out"

if echo "$out" | grep -qxF "Done: no errors"; then
        exit 0
fi
exit 1

// ==== verif/regfile_tb.sv ====
`default_nettype none

module regfile_tb;

        localparam int RESET_CYCLES = 6;     // asserting edge plus five held cycles
        localparam int RAND_CYCLES  = 2000;
        localparam int MAX_CYCLES   = 3 * RESET_CYCLES  // start, test 3, test 5
                                    + 64                // reset readout
                                    + 18                // hot writes and x0
                                    + 5 * 23 + 1        // cold gating
                                    + 4 * 8             // compressed encoding
                                    + RAND_CYCLES
                                    + 50;               // margin

        logic                      clk;
        logic                      rst_n;
        logic [rf_pkg::ADDR_W-1:0] raddr1;
        logic [rf_pkg::ADDR_W-1:0] raddr2;
        logic [rf_pkg::ADDR_W-1:0] waddr;
        logic [rf_pkg::XLEN-1:0]   wdata;
        logic                      wen;
        logic                      is_16;
        logic                      cold_en;
        logic [rf_pkg::XLEN-1:0]   rdata1;
        logic [rf_pkg::XLEN-1:0]   rdata2;
        logic                      cold_err;

        logic [31:0] lfsr;
        logic [63:0] model_regs [32];   // x0 entry stays zero
        logic        model_err;
        int          errors;
        int          checks;
        int          tests;
        int          errs_at_start;
        int          cycles = 0;

        regfile_hot_cold regfile_hot_cold_i (
                .clk        (clk),
                .rst_n      (rst_n),
                .raddr1_i   (raddr1),
                .raddr2_i   (raddr2),
                .waddr_i    (waddr),
                .wdata_i    (wdata),
                .wen_i      (wen),
                .is_16_i    (is_16),
                .cold_en_i  (cold_en),
                .rdata1_o   (rdata1),
                .rdata2_o   (rdata2),
                .cold_err_o (cold_err)
        );

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= MAX_CYCLES) begin
                        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
                        $display("Done: errors found");
                        $finish;
                end
        end

        // ----------------------------------------------------------------------
        // stimulus source and reference model
        // ----------------------------------------------------------------------

        // fibonacci lfsr, taps 32 22 2 1, one step per bit
        function automatic logic [63:0] rand_bits(input int n);
                logic [63:0] v;
                logic        fb;
                v = '0;
                for (int i = 0; i < n; i++) begin
                        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
                        lfsr = {lfsr[30:0], fb};
                        v    = {v[62:0], fb};
                end
                return v;
        endfunction

        function automatic logic is_hot_reg(input logic [4:0] r);
                case (r)
                        5'd1, 5'd2, 5'd5, 5'd6, 5'd7, 5'd8, 5'd10, 5'd11: return 1'b1;
                        default: return 1'b0;
                endcase
        endfunction

        // compressed fields name x8..x15
        function automatic logic [4:0] reg_of(input logic [4:0] a, input logic c16);
                return c16 ? 5'd8 + {2'b00, a[2:0]} : a;
        endfunction

        function automatic logic [63:0] model_read(input logic [4:0] a, input logic c16,
                                                   input logic ce);
                logic [4:0] r;
                r = reg_of(a, c16);
                if (r == 5'd0 || (!is_hot_reg(r) && !ce))
                        return '0;
                return model_regs[r];
        endfunction

        task automatic check_val(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
                end
        endtask

        // one clock of traffic, outputs checked at the falling edge
        task automatic drive_cycle(input logic [4:0] ra1, input logic [4:0] ra2,
                                   input logic [4:0] wa, input logic [63:0] wd,
                                   input logic we, input logic c16, input logic ce);
                logic [4:0] r;
                @(posedge clk);
                raddr1  <= ra1;
                raddr2  <= ra2;
                waddr   <= wa;
                wdata   <= wd;
                wen     <= we;
                is_16   <= c16;
                cold_en <= ce;
                @(negedge clk);
                check_val($sformatf("rdata1_o addr %0d", ra1), rdata1, model_read(ra1, c16, ce));
                check_val($sformatf("rdata2_o addr %0d", ra2), rdata2, model_read(ra2, c16, ce));
                check_val("cold_err_o", 64'(cold_err), 64'(model_err));
                r = reg_of(wa, c16);   // write lands at the next edge
                if (we && r != 5'd0) begin
                        if (is_hot_reg(r) || ce)
                                model_regs[r] = wd;
                        else
                                model_err = 1'b1;
                end
        endtask

        task automatic apply_reset();
                @(posedge clk);
                rst_n <= 1'b0;
                wen   <= 1'b0;
                repeat (5) @(posedge clk);
                rst_n <= 1'b1;
                for (int r = 0; r < 32; r++)
                        model_regs[r] = '0;
                model_err = 1'b0;
        endtask

        task automatic end_test(input string name);
                tests++;
                $display("test %s: %0d mismatches", name, errors - errs_at_start);
                errs_at_start = errors;
        endtask

        // ----------------------------------------------------------------------
        // tests
        // ----------------------------------------------------------------------

        initial begin
                logic [63:0] wd;
                logic [1:0]  up;
                logic [4:0]  ra1;
                logic [4:0]  ra2;
                logic [4:0]  wa;
                logic        we;
                logic        c16;
                logic        ce;

                lfsr = 32'haa9c;
                errors = 0;
                checks = 0;
                tests = 0;
                errs_at_start = 0;
                rst_n <= 1'b0;
                raddr1 <= '0;
                raddr2 <= '0;
                waddr <= '0;
                wdata <= '0;
                wen <= 1'b0;
                is_16 <= 1'b0;
                cold_en <= 1'b0;
                apply_reset();

                for (int m = 0; m < 2; m++)
                        for (int a = 0; a < 32; a++)
                                drive_cycle(5'(a), 5'(31 - a), 5'd0, '0, 1'b0, m[0], 1'b1);
                end_test("reset_state");

                for (int r = 1; r < 32; r++) begin
                        if (is_hot_reg(5'(r))) begin
                                wd = rand_bits(64);
                                drive_cycle(5'(r), 5'(r), 5'(r), wd, 1'b1, 1'b0, 1'b0);
                                drive_cycle(5'(r), 5'(r), 5'd0, '0, 1'b0, 1'b0, 1'b0);
                        end
                end
                drive_cycle(5'd0, 5'd0, 5'd0, rand_bits(64), 1'b1, 1'b0, 1'b1);
                drive_cycle(5'd0, 5'd0, 5'd0, '0, 1'b0, 1'b0, 1'b1);
                end_test("hot_writes");

                for (int r = 1; r < 32; r++) begin
                        if (!is_hot_reg(5'(r))) begin
                                wd = rand_bits(64);
                                drive_cycle(5'(r), 5'(r), 5'(r), wd, 1'b1, 1'b0, 1'b1);
                                drive_cycle(5'(r), 5'(r), 5'd0, '0, 1'b0, 1'b0, 1'b1);
                        end
                end
                for (int r = 1; r < 32; r++) begin
                        if (!is_hot_reg(5'(r))) begin
                                wd = rand_bits(64);
                                drive_cycle(5'(r), 5'(r), 5'(r), wd, 1'b1, 1'b0, 1'b0);
                                drive_cycle(5'(r), 5'(r), 5'd0, '0, 1'b0, 1'b0, 1'b0);
                                drive_cycle(5'(r), 5'(r), 5'd0, '0, 1'b0, 1'b0, 1'b1);
                        end
                end
                apply_reset();
                drive_cycle(5'd1, 5'd3, 5'd0, '0, 1'b0, 1'b0, 1'b0);  // flag cleared
                end_test("cold_gating");

                // upper address bits must not matter in compressed mode
                for (int c = 0; c < 8; c++) begin
                        up = 2'(rand_bits(2));
                        wd = rand_bits(64);
                        drive_cycle({up, 3'(c)}, 5'(c), {up, 3'(c)}, wd, 1'b1, 1'b1, 1'b1);
                        drive_cycle(5'(8 + c), {up, 3'(c)}, 5'd0, '0, 1'b0, 1'b0, 1'b1);
                        drive_cycle({~up, 3'(c)}, 5'(c), {~up, 3'(c)}, ~wd, 1'b1, 1'b1, 1'b0);
                        drive_cycle({up, 3'(c)}, {~up, 3'(c)}, 5'd0, '0, 1'b0, 1'b1, 1'b1);
                end
                end_test("compressed");

                apply_reset();
                for (int n = 0; n < RAND_CYCLES; n++) begin
                        wa  = 5'(rand_bits(5));
                        ra1 = 5'(rand_bits(5));
                        ra2 = 5'(rand_bits(5));
                        if (rand_bits(2) == 64'd0)
                                ra1 = wa;    // same-cycle read sees the old value
                        wd  = rand_bits(64);
                        we  = 1'(rand_bits(1));
                        c16 = 1'(rand_bits(1));
                        ce  = (rand_bits(3) != 64'd0);
                        drive_cycle(ra1, ra2, wa, wd, we, c16, ce);
                end
                end_test("random");

                $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
                if (errors == 0)
                        $display("Done: no errors");
                else
                        $display("Done: errors found");
                $finish;
        end

endmodule

`default_nettype wire

// ==== verif/regfile_sva.sv ====
`default_nettype none

// port level properties of the register file
module regfile_sva (
        input wire                      clk,
        input wire                      rst_n,
        input wire [rf_pkg::ADDR_W-1:0] raddr1_i,
        input wire [rf_pkg::ADDR_W-1:0] raddr2_i,
        input wire                      wen_i,
        input wire                      is_16_i,
        input wire rf_pkg::acc_class_e  wclass_i,   // decoded write class
        input wire [rf_pkg::XLEN-1:0]   rdata1_i,
        input wire [rf_pkg::XLEN-1:0]   rdata2_i,
        input wire                      cold_err_i
);

        x0_read1: assert property (@(posedge clk) disable iff (!rst_n)
                (!is_16_i && raddr1_i == '0) |-> rdata1_i == '0)
                else $error("x0 read on port 1 returned nonzero data");

        x0_read2: assert property (@(posedge clk) disable iff (!rst_n)
                (!is_16_i && raddr2_i == '0) |-> rdata2_i == '0)
                else $error("x0 read on port 2 returned nonzero data");

        // flag only clears through reset
        err_sticky: assert property (@(posedge clk) disable iff (!rst_n)
                !$fell(cold_err_i))
                else $error("cold_err_o dropped without reset");

        err_set: assert property (@(posedge clk) disable iff (!rst_n)
                (wen_i && wclass_i == rf_pkg::ACC_DENIED) |=> cold_err_i)
                else $error("denied write did not raise cold_err_o");

endmodule

bind regfile_hot_cold regfile_sva regfile_sva_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .raddr1_i   (raddr1_i),
        .raddr2_i   (raddr2_i),
        .wen_i      (wen_i),
        .is_16_i    (is_16_i),
        .wclass_i   (wclass),
        .rdata1_i   (rdata1_o),
        .rdata2_i   (rdata2_o),
        .cold_err_i (cold_err_o)
);

`default_nettype wire

// ==== logic/regfile_hot_cold.sv ====
`default_nettype none

// 32 x 64-bit integer register file: x0 hardwired to zero, eight hot
// registers always open, 23 cold registers behind cold_en_i
module regfile_hot_cold (
        input  wire                         clk,
        input  wire                         rst_n,
        input  wire  [rf_pkg::ADDR_W-1:0]   raddr1_i,
        input  wire  [rf_pkg::ADDR_W-1:0]   raddr2_i,
        input  wire  [rf_pkg::ADDR_W-1:0]   waddr_i,
        input  wire  [rf_pkg::XLEN-1:0]     wdata_i,
        input  wire                         wen_i,
        input  wire                         is_16_i,    // compressed register fields
        input  wire                         cold_en_i,  // cold bank access allowed
        output logic [rf_pkg::XLEN-1:0]     rdata1_o,
        output logic [rf_pkg::XLEN-1:0]     rdata2_o,
        output logic                        cold_err_o  // sticky, refused write seen
);

        rf_pkg::acc_class_e        rclass1;
        rf_pkg::acc_class_e        rclass2;
        rf_pkg::acc_class_e        wclass;
        logic [rf_pkg::SLOT_W-1:0] rslot1;
        logic [rf_pkg::SLOT_W-1:0] rslot2;
        logic [rf_pkg::SLOT_W-1:0] wslot;

        logic                      hot_we;
        logic                      cold_we;
        logic [rf_pkg::XLEN-1:0]   hot_rdata1;
        logic [rf_pkg::XLEN-1:0]   hot_rdata2;
        logic [rf_pkg::XLEN-1:0]   cold_rdata1;
        logic [rf_pkg::XLEN-1:0]   cold_rdata2;

        // ----------------------------------------------------------------------
        // address decode, one per port
        // ----------------------------------------------------------------------

        rf_addr_map rd1_map_i (
                .addr_i    (raddr1_i),
                .is_16_i   (is_16_i),
                .cold_en_i (cold_en_i),
                .class_o   (rclass1),
                .slot_o    (rslot1)
        );

        rf_addr_map rd2_map_i (
                .addr_i    (raddr2_i),
                .is_16_i   (is_16_i),
                .cold_en_i (cold_en_i),
                .class_o   (rclass2),
                .slot_o    (rslot2)
        );

        rf_addr_map wr_map_i (
                .addr_i    (waddr_i),
                .is_16_i   (is_16_i),
                .cold_en_i (cold_en_i),
                .class_o   (wclass),
                .slot_o    (wslot)
        );

        // ----------------------------------------------------------------------
        // storage
        // ----------------------------------------------------------------------

        rf_bank #(.DEPTH(rf_pkg::HOT_COUNT)) hot_bank_i (
                .clk      (clk),
                .rst_n    (rst_n),
                .we_i     (hot_we),
                .wslot_i  (wslot),
                .wdata_i  (wdata_i),
                .rslot1_i (rslot1),
                .rslot2_i (rslot2),
                .rdata1_o (hot_rdata1),
                .rdata2_o (hot_rdata2)
        );

        rf_bank #(.DEPTH(rf_pkg::COLD_COUNT)) cold_bank_i (
                .clk      (clk),
                .rst_n    (rst_n),
                .we_i     (cold_we),
                .wslot_i  (wslot),
                .wdata_i  (wdata_i),
                .rslot1_i (rslot1),
                .rslot2_i (rslot2),
                .rdata1_o (cold_rdata1),
                .rdata2_o (cold_rdata2)
        );

        // ----------------------------------------------------------------------
        // access control
        // ----------------------------------------------------------------------

        rf_access_ctrl access_ctrl_i (
                .clk           (clk),
                .rst_n         (rst_n),
                .wen_i         (wen_i),
                .wclass_i      (wclass),
                .rclass1_i     (rclass1),
                .rclass2_i     (rclass2),
                .hot_we_o      (hot_we),
                .cold_we_o     (cold_we),
                .hot_rdata1_i  (hot_rdata1),
                .hot_rdata2_i  (hot_rdata2),
                .cold_rdata1_i (cold_rdata1),
                .cold_rdata2_i (cold_rdata2),
                .rdata1_o      (rdata1_o),
                .rdata2_o      (rdata2_o),
                .cold_err_o    (cold_err_o)
        );

endmodule

`default_nettype wire

// ==== logic/rf_access_ctrl.sv ====
`default_nettype none

// routes the write to one bank, picks read data per port and keeps the
// sticky flag for writes refused by a closed cold bank
module rf_access_ctrl (
        input  wire                           clk,
        input  wire                           rst_n,

        input  wire                           wen_i,
        input  wire  rf_pkg::acc_class_e      wclass_i,
        input  wire  rf_pkg::acc_class_e      rclass1_i,
        input  wire  rf_pkg::acc_class_e      rclass2_i,

        output logic                          hot_we_o,
        output logic                          cold_we_o,

        input  wire  [rf_pkg::XLEN-1:0]       hot_rdata1_i,
        input  wire  [rf_pkg::XLEN-1:0]       hot_rdata2_i,
        input  wire  [rf_pkg::XLEN-1:0]       cold_rdata1_i,
        input  wire  [rf_pkg::XLEN-1:0]       cold_rdata2_i,

        output logic [rf_pkg::XLEN-1:0]       rdata1_o,
        output logic [rf_pkg::XLEN-1:0]       rdata2_o,
        output logic                          cold_err_o
);

        logic denied_wr;   // write hit the cold bank while it was closed
        logic cold_err_q;

        // ----------------------------------------------------------------------
        // write steering
        // ----------------------------------------------------------------------

        // x0 and denied writes reach no bank
        assign hot_we_o  = wen_i && (wclass_i == rf_pkg::ACC_HOT);
        assign cold_we_o = wen_i && (wclass_i == rf_pkg::ACC_COLD);

        assign denied_wr = wen_i && (wclass_i == rf_pkg::ACC_DENIED);

        // ----------------------------------------------------------------------
        // read data select
        // ----------------------------------------------------------------------

        function automatic logic [rf_pkg::XLEN-1:0] pick_rdata(
                input rf_pkg::acc_class_e      cls,
                input logic [rf_pkg::XLEN-1:0] hot_data,
                input logic [rf_pkg::XLEN-1:0] cold_data
        );
                logic [rf_pkg::XLEN-1:0] data;

                case (cls)
                        rf_pkg::ACC_HOT:  data = hot_data;
                        rf_pkg::ACC_COLD: data = cold_data;
                        default:          data = '0;  // x0, or cold bank closed
                endcase
                return data;
        endfunction

        assign rdata1_o = pick_rdata(rclass1_i, hot_rdata1_i, cold_rdata1_i);
        assign rdata2_o = pick_rdata(rclass2_i, hot_rdata2_i, cold_rdata2_i);

        // ----------------------------------------------------------------------
        // sticky error flag
        // ----------------------------------------------------------------------

        // set by the first refused write, held until reset
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        cold_err_q <= 1'b0;
                end else if (denied_wr) begin
                        cold_err_q <= 1'b1;
                end
        end

        assign cold_err_o = cold_err_q;

endmodule

`default_nettype wire

// ==== logic/rf_bank.sv ====
`default_nettype none

// DEPTH x XLEN storage, one write port at the clock edge and two
// combinational read ports
module rf_bank #(
        parameter int DEPTH = 8
) (
        input  wire                       clk,
        input  wire                       rst_n,
        input  wire                       we_i,
        input  wire  [rf_pkg::SLOT_W-1:0] wslot_i,
        input  wire  [rf_pkg::XLEN-1:0]   wdata_i,
        input  wire  [rf_pkg::SLOT_W-1:0] rslot1_i,
        input  wire  [rf_pkg::SLOT_W-1:0] rslot2_i,
        output logic [rf_pkg::XLEN-1:0]   rdata1_o,
        output logic [rf_pkg::XLEN-1:0]   rdata2_o
);

        logic [rf_pkg::XLEN-1:0] regs_q [DEPTH];

        // ----------------------------------------------------------------------
        // write port
        // ----------------------------------------------------------------------

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < DEPTH; i++)
                                regs_q[i] <= '0;
                end else begin
                        // slots past DEPTH match nothing and are dropped
                        for (int i = 0; i < DEPTH; i++) begin
                                if (we_i && int'(wslot_i) == i)
                                        regs_q[i] <= wdata_i;
                        end
                end
        end

        // ----------------------------------------------------------------------
        // read ports
        // ----------------------------------------------------------------------

        // no write bypass, a same-cycle read sees the old word
        always_comb begin
                rdata1_o = '0;  // out of range slot reads zero
                rdata2_o = '0;
                for (int i = 0; i < DEPTH; i++) begin
                        if (int'(rslot1_i) == i)
                                rdata1_o = regs_q[i];
                        if (int'(rslot2_i) == i)
                                rdata2_o = regs_q[i];
                end
        end

endmodule

`default_nettype wire

// ==== logic/rf_addr_map.sv ====
`default_nettype none

// decodes one architectural address into an access class and a packed
// slot index inside the bank that holds the register
module rf_addr_map (
        input  wire        [rf_pkg::ADDR_W-1:0] addr_i,
        input  wire                             is_16_i,    // compressed encoding
        input  wire                             cold_en_i,  // cold bank open
        output rf_pkg::acc_class_e              class_o,
        output logic       [rf_pkg::SLOT_W-1:0] slot_o
);

        logic [rf_pkg::ADDR_W-1:0] reg_num;   // register actually named
        logic                      is_hot;
        int                        hot_cnt;   // hot registers below reg_num
        int                        cold_cnt;  // cold registers below reg_num

        // ----------------------------------------------------------------------
        // register number
        // ----------------------------------------------------------------------

        always_comb begin
                if (is_16_i) begin
                        // low field offset from x8
                        reg_num = rf_pkg::C_BASE
                                + {{(rf_pkg::ADDR_W - rf_pkg::C_FIELD_W){1'b0}},
                                   addr_i[rf_pkg::C_FIELD_W-1:0]};
                end else begin
                        reg_num = addr_i;
                end
        end

        assign is_hot = rf_pkg::HOT_MASK[reg_num];

        // ----------------------------------------------------------------------
        // dense slot numbering
        // ----------------------------------------------------------------------

        // count members of each bank below this register, x0 left out
        always_comb begin
                hot_cnt  = 0;
                cold_cnt = 0;
                for (int r = 1; r < rf_pkg::NUM_REGS; r++) begin
                        if (r < int'(reg_num)) begin
                                if (rf_pkg::HOT_MASK[r])
                                        hot_cnt = hot_cnt + 1;
                                else
                                        cold_cnt = cold_cnt + 1;
                        end
                end
        end

        // ----------------------------------------------------------------------
        // class and slot
        // ----------------------------------------------------------------------

        always_comb begin
                if (reg_num == '0) begin
                        class_o = rf_pkg::ACC_ZERO;
                        slot_o  = '0;
                end else if (is_hot) begin
                        class_o = rf_pkg::ACC_HOT;
                        slot_o  = rf_pkg::SLOT_W'(hot_cnt);
                end else begin
                        class_o = cold_en_i ? rf_pkg::ACC_COLD : rf_pkg::ACC_DENIED;
                        slot_o  = rf_pkg::SLOT_W'(cold_cnt);  // unused when denied
                end
        end

endmodule

`default_nettype wire

// ==== logic/rf_pkg.sv ====
`default_nettype none

package rf_pkg;

        // ----------------------------------------------------------------------
        // widths and counts
        // ----------------------------------------------------------------------

        localparam int XLEN       = 64;  // data word
        localparam int ADDR_W     = 5;   // architectural register address
        localparam int NUM_REGS   = 32;  // x0..x31, x0 included

        localparam int HOT_COUNT  = 8;   // x1 x2 x5 x6 x7 x8 x10 x11
        localparam int COLD_COUNT = 23;  // everything else except x0

        // slot index into either bank, wide enough for the cold bank
        localparam int SLOT_W     = 5;

        // ----------------------------------------------------------------------
        // compressed (16-bit instruction) register encoding
        // ----------------------------------------------------------------------

        // three-bit field selects x8..x15
        localparam int C_FIELD_W  = 3;
        localparam logic [ADDR_W-1:0] C_BASE = 5'd8;

        // ----------------------------------------------------------------------
        // hot bank membership
        // ----------------------------------------------------------------------

        // one bit per register; set means the register lives in the hot bank
        // bits 1, 2, 5, 6, 7, 8, 10, 11
        localparam logic [NUM_REGS-1:0] HOT_MASK = 32'h0000_0de6;

        // ----------------------------------------------------------------------
        // access classes
        // ----------------------------------------------------------------------

        // result of decoding one address against the current cold_en state
        typedef enum logic [1:0] {
                ACC_ZERO   = 2'd0,  // x0, reads zero, writes dropped
                ACC_HOT    = 2'd1,  // hot bank register
                ACC_COLD   = 2'd2,  // cold bank register, bank open
                ACC_DENIED = 2'd3   // cold bank register while cold_en is low
        } acc_class_e;

endpackage

`default_nettype wire
